// ==== design/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data word and register file geometry
`define RV_XLEN     32
`define RV_NUM_REGS 32
// commit order counter width
`define RV_ORDER_W  64

`endif

// ==== design/rv32i_isa_pkg.sv ====
`include "rv_defines.svh"

package rv32i_isa_pkg;

    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_t;

    // major opcodes, only OP, OP_IMM, LUI and AUIPC are executed
    typedef enum logic [6:0] {
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        BRANCH   = 7'b1100011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP       = 7'b0110011,
        MISC_MEM = 7'b0001111,
        SYSTEM   = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_t       rs2;
        reg_t       rs1;
        funct3_e    funct3;
        reg_t       rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_t        rs1;
        funct3_e     funct3;
        reg_t        rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_t        rd;
        opcode_e     opcode;
    } u_type_t;

    // one instruction word seen through each encoding format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } instr_u;

    typedef struct packed {
        logic [`RV_XLEN-1:0] i_imm;
        logic [`RV_XLEN-1:0] s_imm;
        logic [`RV_XLEN-1:0] b_imm;
        logic [`RV_XLEN-1:0] u_imm;
        logic [`RV_XLEN-1:0] j_imm;
    } imm_t;

endpackage

// ==== design/pipe_pkg.sv ====
`include "rv_defines.svh"

package pipe_pkg;

    typedef struct packed {
        logic [`RV_ORDER_W-1:0]  order;
        logic [`RV_XLEN-1:0]     pc;
        rv32i_isa_pkg::instr_u   instr;
        rv32i_isa_pkg::opcode_e  opcode;
        rv32i_isa_pkg::funct3_e  funct3;
        logic [6:0]              funct7;
        rv32i_isa_pkg::reg_t     rs1_addr;
        logic [`RV_XLEN-1:0]     rs1_data;
        rv32i_isa_pkg::reg_t     rs2_addr;
        logic [`RV_XLEN-1:0]     rs2_data;
        rv32i_isa_pkg::reg_t     rd_addr;
        rv32i_isa_pkg::imm_t     imm;
    } decode_out_t;

    typedef struct packed {
        logic [`RV_ORDER_W-1:0]  order;
        logic [`RV_XLEN-1:0]     pc;
        rv32i_isa_pkg::instr_u   instr;
        rv32i_isa_pkg::reg_t     rd_addr;
        logic [`RV_XLEN-1:0]     result;
        logic                    illegal;
    } exec_out_t;

    // the retire port carries exactly what writeback holds
    typedef exec_out_t retire_t;

endpackage

// ==== design/regfile.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module regfile (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        we,
    input  rv32i_isa_pkg::reg_t         waddr,
    input  logic [`RV_XLEN-1:0]         wdata,
    input  rv32i_isa_pkg::reg_t         raddr_a,
    input  rv32i_isa_pkg::reg_t         raddr_b,
    output logic [`RV_XLEN-1:0]         rdata_a,
    output logic [`RV_XLEN-1:0]         rdata_b
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // a write in flight is seen by a read in the same cycle
    assign rdata_a = (raddr_a == '0)                  ? '0    :
                     (we && (waddr == raddr_a))       ? wdata :
                                                        regs[raddr_a];
    assign rdata_b = (raddr_b == '0)                  ? '0    :
                     (we && (waddr == raddr_b))       ? wdata :
                                                        regs[raddr_b];

    // writeback must already have filtered out writes to x0
    a_no_x0_write : assert property (
        @(posedge clk) disable iff (!arst_n) we |-> (waddr != '0)
    );

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    instr_valid,
    input  logic [31:0]             instr,
    input  logic [31:0]             pc,
    input  logic                    rf_we,
    input  rv32i_isa_pkg::reg_t     rf_waddr,
    input  logic [`RV_XLEN-1:0]     rf_wdata,
    output logic                    dec_valid,
    output pipe_pkg::decode_out_t   dec
);

    rv32i_isa_pkg::instr_u   iw;
    rv32i_isa_pkg::imm_t     imm;
    pipe_pkg::decode_out_t   dec_d;
    logic [`RV_XLEN-1:0]     rs1_data;
    logic [`RV_XLEN-1:0]     rs2_data;
    logic [`RV_ORDER_W-1:0]  order_q;

    assign iw = instr;

    assign imm.i_imm = {{(`RV_XLEN-12){iw.i.imm12[11]}}, iw.i.imm12};
    assign imm.s_imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm.b_imm = {{(`RV_XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm.u_imm = {iw.u.imm20, 12'h000};
    assign imm.j_imm = {{(`RV_XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    regfile u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .raddr_a (iw.r.rs1),
        .raddr_b (iw.r.rs2),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    always_comb begin
        dec_d          = '0;
        dec_d.order    = order_q;
        dec_d.pc       = pc;
        dec_d.instr    = iw;
        dec_d.opcode   = iw.r.opcode;
        dec_d.funct3   = iw.r.funct3;
        dec_d.funct7   = iw.r.funct7;
        dec_d.rs1_addr = iw.r.rs1;
        dec_d.rs1_data = rs1_data;
        dec_d.rs2_addr = iw.r.rs2;
        dec_d.rs2_data = rs2_data;
        dec_d.rd_addr  = iw.r.rd;
        dec_d.imm      = imm;
    end

    // order numbers follow acceptance, so idle cycles leave no gaps
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            order_q   <= '0;
        end else begin
            dec_valid <= instr_valid;
            if (instr_valid) begin
                order_q <= order_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec <= dec_d;
        end
    end

    a_dec_valid_known : assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(dec_valid)
    );

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module execute_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    dec_valid,
    input  pipe_pkg::decode_out_t   dec,
    input  logic                    wb_valid,
    input  pipe_pkg::exec_out_t     wb,
    output logic                    ex_valid,
    output pipe_pkg::exec_out_t     ex
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0]  rs1_val;
    logic [`RV_XLEN-1:0]  rs2_val;
    logic [`RV_XLEN-1:0]  op_b;
    logic [`RV_XLEN-1:0]  result;
    logic [SHAMT_W-1:0]   shamt;
    logic                 is_op;
    logic                 alt;
    logic                 legal;
    pipe_pkg::exec_out_t  ex_d;

    function automatic logic fwd_hit(
        input logic                 valid,
        input pipe_pkg::exec_out_t  src,
        input rv32i_isa_pkg::reg_t  addr
    );
        return valid && !src.illegal && (src.rd_addr != '0) && (src.rd_addr == addr);
    endfunction

    // the instruction one ahead sits in the ex register and the one two ahead sits in writeback
    // the nearer one wins
    always_comb begin
        rs1_val = dec.rs1_data;
        if (fwd_hit(ex_valid, ex, dec.rs1_addr)) begin
            rs1_val = ex.result;
        end else if (fwd_hit(wb_valid, wb, dec.rs1_addr)) begin
            rs1_val = wb.result;
        end
        rs2_val = dec.rs2_data;
        if (fwd_hit(ex_valid, ex, dec.rs2_addr)) begin
            rs2_val = ex.result;
        end else if (fwd_hit(wb_valid, wb, dec.rs2_addr)) begin
            rs2_val = wb.result;
        end
    end

    assign is_op = (dec.opcode == rv32i_isa_pkg::OP);
    assign op_b  = is_op ? rs2_val : dec.imm.i_imm;
    assign shamt = op_b[SHAMT_W-1:0];
    // instruction bit 30 picks sub and sra as well as srai
    assign alt   = dec.funct7[5];

    always_comb begin
        legal  = 1'b1;
        result = '0;
        case (dec.opcode)
            rv32i_isa_pkg::OP, rv32i_isa_pkg::OP_IMM: begin
                case (dec.funct3)
                    rv32i_isa_pkg::F3_ADD:  result = (is_op && alt) ? rs1_val - op_b : rs1_val + op_b;
                    rv32i_isa_pkg::F3_SLL:  result = rs1_val << shamt;
                    rv32i_isa_pkg::F3_SLT:  result = {{(`RV_XLEN-1){1'b0}},
                                                      $signed(rs1_val) < $signed(op_b)};
                    rv32i_isa_pkg::F3_SLTU: result = {{(`RV_XLEN-1){1'b0}}, rs1_val < op_b};
                    rv32i_isa_pkg::F3_XOR:  result = rs1_val ^ op_b;
                    rv32i_isa_pkg::F3_SR: begin
                        if (alt) begin
                            result = $signed(rs1_val) >>> shamt;
                        end else begin
                            result = rs1_val >> shamt;
                        end
                    end
                    rv32i_isa_pkg::F3_OR:   result = rs1_val | op_b;
                    rv32i_isa_pkg::F3_AND:  result = rs1_val & op_b;
                endcase
            end
            rv32i_isa_pkg::LUI:   result = dec.imm.u_imm;
            rv32i_isa_pkg::AUIPC: result = dec.pc + dec.imm.u_imm;
            default:              legal  = 1'b0;
        endcase
    end

    always_comb begin
        ex_d         = '0;
        ex_d.order   = dec.order;
        ex_d.pc      = dec.pc;
        ex_d.instr   = dec.instr;
        ex_d.rd_addr = dec.rd_addr;
        ex_d.result  = result;
        ex_d.illegal = dec_valid && !legal;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex <= ex_d;
    end

    // an illegal instruction leaves execute as a valid slot with a zero result
    a_illegal_needs_valid : assert property (
        @(posedge clk) disable iff (!arst_n) ex.illegal |-> (ex_valid && (ex.result == '0))
    );

endmodule

// ==== design/writeback_stage.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module writeback_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    ex_valid,
    input  pipe_pkg::exec_out_t     ex,
    output logic                    rf_we,
    output rv32i_isa_pkg::reg_t     rf_waddr,
    output logic [`RV_XLEN-1:0]     rf_wdata,
    output logic                    fwd_valid,
    output pipe_pkg::exec_out_t     fwd,
    output logic                    retire_valid,
    output pipe_pkg::retire_t       retire
);

    logic                 wb_valid;
    pipe_pkg::exec_out_t  wb_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_q <= ex;
    end

    // illegal instructions and x0 targets retire without a register write
    assign rf_we        = wb_valid && !wb_q.illegal && (wb_q.rd_addr != '0);
    assign rf_waddr     = wb_q.rd_addr;
    assign rf_wdata     = wb_q.result;
    assign fwd_valid    = wb_valid;
    assign fwd          = wb_q;
    assign retire_valid = wb_valid;
    assign retire       = wb_q;

endmodule

// ==== design/rv_core_top.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                instr_valid,
    input  logic [31:0]         instr,
    input  logic [31:0]         pc,
    output logic                retire_valid,
    output pipe_pkg::retire_t   retire
);

    logic                    dec_valid;
    pipe_pkg::decode_out_t   dec;
    logic                    ex_valid;
    pipe_pkg::exec_out_t     ex;
    logic                    fwd_valid;
    pipe_pkg::exec_out_t     fwd;
    logic                    rf_we;
    rv32i_isa_pkg::reg_t     rf_waddr;
    logic [`RV_XLEN-1:0]     rf_wdata;

    decode_stage u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    execute_stage u_execute (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .wb_valid  (fwd_valid),
        .wb        (fwd),
        .ex_valid  (ex_valid),
        .ex        (ex)
    );

    writeback_stage u_writeback (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex_valid     (ex_valid),
        .ex           (ex),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .fwd_valid    (fwd_valid),
        .fwd          (fwd),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

    localparam int NUM_PATTERNS = 24;
    localparam int FIELDS       = 5;
    localparam int DONE_TIMEOUT = 200;

    logic               clk;
    logic               arst_n;
    logic               instr_valid;
    logic [31:0]        instr;
    logic [31:0]        pc;
    logic               retire_valid;
    pipe_pkg::retire_t  retire;

    logic [31:0]        pat_mem [NUM_PATTERNS*FIELDS];
    integer             seed;
    int                 retire_count;
    logic [2:0]         valid_pipe;

    rv_core_top u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_instr(input logic [31:0] word, input logic [31:0] addr);
        @(posedge clk);
        #2;
        instr_valid = 1'b1;
        instr       = word;
        pc          = addr;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
    endtask

    // an instruction sampled at rising edge e is on retire at the falling edge after edge e+2
    always @(negedge clk) begin
        int base;
        if (!arst_n) begin
            valid_pipe = '0;
        end else begin
            check_value("retire_valid", 64'(retire_valid), 64'(valid_pipe[2]));
            if (retire_valid && (retire_count >= NUM_PATTERNS)) begin
                fail_run("more instructions retired than were issued");
            end else if (retire_valid) begin
                base = retire_count * FIELDS;
                check_value("retire.order", retire.order, 64'(retire_count));
                check_value("retire.instr", 64'(retire.instr), 64'(pat_mem[base]));
                check_value("retire.pc", 64'(retire.pc), 64'(pat_mem[base+1]));
                check_value("retire.rd_addr", 64'(retire.rd_addr), 64'(pat_mem[base+2]));
                check_value("retire.result", 64'(retire.result), 64'(pat_mem[base+3]));
                check_value("retire.illegal", 64'(retire.illegal), 64'(pat_mem[base+4]));
                retire_count++;
            end
            valid_pipe = {valid_pipe[1:0], instr_valid};
        end
    end

    initial begin
        int          i;
        int          idle;
        int          waited;
        logic [31:0] prev_pc;
        seed         = 32'h4a26_af81;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        pc           = '0;
        retire_count = 0;
        prev_pc      = '0;
        for (i = 0; i < NUM_PATTERNS*FIELDS; i++) begin
            pat_mem[i] = 32'hffff_0000 | i;
        end
        $readmemh("testbench/rv_core_patterns.mem", pat_mem);
        // an entry still holding the fill value shows up as an out of range rd or flag
        for (i = 0; i < NUM_PATTERNS; i++) begin
            if ((pat_mem[i*FIELDS+2] > 31) || (pat_mem[i*FIELDS+4] > 1)) begin
                fail_run("pattern file is missing or has too few entries");
            end
        end

        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;

        for (i = 0; i < NUM_PATTERNS; i++) begin
            // a dependent chain keeps consecutive pcs and must issue without gaps
            if ((i == 0) || (pat_mem[i*FIELDS+1] != prev_pc + 32'd4)) begin
                idle = $unsigned($random(seed)) % 3;
                repeat (idle) drive_idle();
            end
            drive_instr(pat_mem[i*FIELDS], pat_mem[i*FIELDS+1]);
            prev_pc = pat_mem[i*FIELDS+1];
        end
        drive_idle();

        waited = 0;
        while ((retire_count < NUM_PATTERNS) && (waited < DONE_TIMEOUT)) begin
            @(posedge clk);
            waited++;
        end
        if (retire_count < NUM_PATTERNS) begin
            fail_run("timed out waiting for all instructions to retire");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+design
design/rv32i_isa_pkg.sv
design/pipe_pkg.sv
design/regfile.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/rv_core_top.sv
testbench/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the pipeline testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module tb_rv_core \
    -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/tb_rv_core)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "RESULT: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== testbench/rv_core_patterns.mem ====
// columns: instruction, pc, expected rd, expected result, expected illegal flag
// consecutive pcs issue back to back, a jump in pc allows idle cycles before it
12300093 00000100 01 00000123 0
fff00113 00000110 02 ffffffff 0
00012193 00000120 03 00000001 0
fff0b213 00000130 04 00000001 0
0f00c293 00000140 05 000001d3 0
7000e313 00000150 06 00000723 0
5a517393 00000160 07 000005a5 0
00409413 00000170 08 00001230 0
01c15493 00000180 09 0000000f 0
800005b7 00000190 0b 80000000 0
4045d513 000001a0 0a f8000000 0
12345617 000001b0 0c 123451b0 0
007086b3 00000200 0d 000006c8 0
40708733 00000210 0e fffffb7e 0
4095d7b3 00000220 0f ffff0000 0
00172833 00000230 10 00000001 0
00700a13 00000300 14 00000007 0
014a0ab3 00000304 15 0000000e 0
414a8b33 00000308 16 00000007 0
015a6bb3 0000030c 17 0000000f 0
005b8013 00000310 00 00000014 0
01600c33 00000314 18 00000007 0
00002c03 00000400 18 00000000 1
001c0c93 00000404 19 00000008 0
